//--- list.f
+incdir+verification
verilog/cordic_div_pkg.sv
verilog/cordic_div_control.sv
verilog/cordic_shift_select.sv
verilog/cordic_div_datapath.sv
verilog/cordic_divider.sv
verification/cordic_divider_tb.sv

//--- verification/cordic_div_tb_tasks.svh
/*
 * cordic divider testbench tasks
 * integer reference model, random generator and directed tests
 */

`ifndef cordic_div_tb_tasks_svh
`define cordic_div_tb_tasks_svh

// 32 bit linear congruential generator
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// wrap to a data word, read back as signed
function automatic longint wrap_data(input longint v);
    longint w;
    w = v & ((longint'(1) << cordic_div_pkg::data_w) - 1);
    if (w[cordic_div_pkg::data_w-1]) begin
        w = w - (longint'(1) << cordic_div_pkg::data_w);
    end
    return w;
endfunction

// quotient and number of enabled cycles, from the algorithm rule
function automatic logic [cordic_div_pkg::result_w-1:0] expected_quotient(
    input  logic [cordic_div_pkg::data_w-1:0] a,
    input  logic [cordic_div_pkg::data_w-1:0] b,
    output int                                cycles
);
    longint x;
    longint y;
    longint z;
    longint t;
    longint ya;
    int     sh;
    int     i;
    int     steps;
    x = longint'($signed(b));
    y = longint'($signed(a));
    // magnitudes wrap like the word registers
    x = (x < 0) ? wrap_data(-x) : x;
    y = (y < 0) ? wrap_data(-y) : y;
    z = 0;
    steps = 0;
    cycles = 0;
    while (cycles <= cordic_div_pkg::max_steps) begin
        cycles++;
        ya = ((y < 0) ? -y : y) & ((longint'(1) << cordic_div_pkg::data_w) - 1);
        // threshold base is 1.5 * x
        t  = x + (x >>> 1);
        sh = cordic_div_pkg::max_shift;
        for (i = cordic_div_pkg::max_shift - 1; i >= 1; i--) begin
            if (ya >= (t >>> (i + 1))) begin
                sh = i;
            end
        end
        if (sh >= cordic_div_pkg::stop_shift || y <= 1 || steps >= cordic_div_pkg::max_steps) begin
            break;
        end
        if (y >= 0) begin
            y = wrap_data(y - (x >>> sh));
            z = wrap_data(z + (longint'(1) << (cordic_div_pkg::frac_w - sh)));
        end else begin
            y = wrap_data(y + (x >>> sh));
            z = wrap_data(z - (longint'(1) << (cordic_div_pkg::frac_w - sh)));
        end
        steps++;
    end
    z = (a[cordic_div_pkg::data_w-1] ^ b[cordic_div_pkg::data_w-1]) ? -z : z;
    return cordic_div_pkg::result_w'(z);
endfunction

//////////////////////////////////////////////////////////////////////
// drive and wait
//////////////////////////////////////////////////////////////////////

// init high for one edge, operands ride along with it
task automatic pulse_init(
    input logic [cordic_div_pkg::data_w-1:0] a,
    input logic [cordic_div_pkg::data_w-1:0] b
);
    @(posedge clk);
    init     <= 1'b1;
    dividend <= a;
    divisor  <= b;
    @(posedge clk);
    init <= 1'b0;
endtask

// lat counts edges after the init edge, done sampled mid cycle
task automatic wait_for_done(output bit seen, output int lat);
    seen = 1'b0;
    lat  = 0;
    while (!seen && lat < cordic_div_pkg::max_steps + 1) begin
        @(posedge clk);
        lat++;
        @(negedge clk);
        if (done) begin
            seen = 1'b1;
        end
    end
endtask

task automatic run_division(
    input  logic [cordic_div_pkg::data_w-1:0]   a,
    input  logic [cordic_div_pkg::data_w-1:0]   b,
    output logic [cordic_div_pkg::result_w-1:0] q,
    output int                                  lat
);
    logic [cordic_div_pkg::result_w-1:0] exp_q;
    int                                  cyc;
    bit                                  seen;
    exp_q = expected_quotient(a, b, cyc);
    pulse_init(a, b);
    wait_for_done(seen, lat);
    q = quotient;
    check_cnt++;
    if (!seen) begin
        $display("no done within %0d cycles for %h / %h", lat, a, b);
        err_cnt++;
    end else if (quotient !== exp_q || lat != cyc) begin
        $display("Fail quotient for %h / %h: got %h after %0d cycles, expected %h after %0d",
                 a, b, quotient, lat, exp_q, cyc);
        err_cnt++;
    end
endtask

// one report line per test
task automatic close_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt == err_before) begin
        $display("%s: ok", name);
    end else begin
        $display("%s: %0d errors", name, err_cnt - err_before);
    end
endtask

//////////////////////////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////////////////////////

task automatic reset_state_check();
    int e0;
    e0 = err_cnt;
    repeat (4) begin
        @(negedge clk);
        check_cnt++;
        if (done !== 1'b0 || quotient !== '0) begin
            $display("Fail done %h quotient %h after reset, expected 0 and 0", done, quotient);
            err_cnt++;
        end
    end
    close_test("reset state", e0);
endtask

task automatic sign_quadrants();
    logic [cordic_div_pkg::data_w-1:0]   a;
    logic [cordic_div_pkg::data_w-1:0]   b;
    logic [cordic_div_pkg::result_w-1:0] q;
    logic [cordic_div_pkg::result_w-1:0] exp_q;
    logic                                sgn;
    int                                  cyc;
    int                                  lat;
    int                                  e0;
    int                                  k;
    e0 = err_cnt;
    for (k = 0; k < 4; k++) begin
        // 2.5 / 0.75 in each sign combination
        a = k[0] ? -21'h2_8000 : 21'h2_8000;
        b = k[1] ? -21'h0_c000 : 21'h0_c000;
        sgn = a[cordic_div_pkg::data_w-1] ^ b[cordic_div_pkg::data_w-1];
        exp_q = expected_quotient(a, b, cyc);
        run_division(a, b, q, lat);
        check_cnt++;
        if (exp_q != '0 && q[cordic_div_pkg::result_w-1] !== sgn) begin
            $display("Fail quotient sign: got %h expected %h",
                     q[cordic_div_pkg::result_w-1], sgn);
            err_cnt++;
        end
    end
    close_test("sign quadrants", e0);
endtask

task automatic zero_and_limit_cases();
    logic [cordic_div_pkg::result_w-1:0] q;
    int                                  lat;
    int                                  e0;
    e0 = err_cnt;
    // zero dividend stops in the first enabled cycle
    run_division('0, 21'h1_8000, q, lat);
    check_cnt++;
    if (lat != 1 || q !== '0) begin
        $display("Fail quotient %h after %0d cycles for a zero dividend, expected 0 after 1",
                 q, lat);
        err_cnt++;
    end
    // zero divisor only ends through the step limit
    run_division(21'h3_0000, '0, q, lat);
    close_test("zero and limit cases", e0);
endtask

task automatic random_operands();
    logic [cordic_div_pkg::data_w-1:0]   a;
    logic [cordic_div_pkg::data_w-1:0]   b;
    logic [cordic_div_pkg::result_w-1:0] q;
    logic [cordic_div_pkg::result_w-1:0] exp_q;
    logic [31:0]                         r;
    int                                  cyc;
    int                                  lat;
    int                                  e0;
    int                                  k;
    e0 = err_cnt;
    for (k = 0; k < 20; k++) begin
        r = lcg_next();
        a = r[31:11];
        // redraw until the divisor is non-zero
        do begin
            r = lcg_next();
            b = r[31:11];
        end while (b == '0);
        exp_q = expected_quotient(a, b, cyc);
        run_division(a, b, q, lat);
        // result stays put with done low until the next init
        repeat (3) begin
            @(negedge clk);
            check_cnt++;
            if (quotient !== exp_q || done !== 1'b0) begin
                $display("Fail quotient %h done %h while idle, expected %h and 0",
                         quotient, done, exp_q);
                err_cnt++;
            end
        end
    end
    close_test("random operands", e0);
endtask

task automatic restart_during_run();
    logic [cordic_div_pkg::data_w-1:0]   a;
    logic [cordic_div_pkg::data_w-1:0]   b;
    logic [cordic_div_pkg::result_w-1:0] exp_q;
    int                                  cyc;
    int                                  lat;
    int                                  pulses;
    int                                  e0;
    bit                                  seen;
    e0 = err_cnt;
    pulses = 0;
    // zero divisor keeps the first run busy for the whole step budget
    pulse_init(21'h3_0000, '0);
    repeat (3) begin
        @(negedge clk);
        if (done) begin
            pulses++;
        end
    end
    a = 21'h1_4000;
    b = -21'h0_a000;
    exp_q = expected_quotient(a, b, cyc);
    pulse_init(a, b);
    wait_for_done(seen, lat);
    if (seen) begin
        pulses++;
    end
    check_cnt++;
    if (quotient !== exp_q) begin
        $display("Fail quotient after restart: got %h expected %h", quotient, exp_q);
        err_cnt++;
    end
    // no late pulse from the abandoned run
    repeat (cordic_div_pkg::max_steps + 2) begin
        @(negedge clk);
        if (done) begin
            pulses++;
        end
    end
    check_cnt++;
    if (pulses != 1) begin
        $display("restart gave %0d done pulses instead of exactly one", pulses);
        err_cnt++;
    end
    close_test("restart during run", e0);
endtask

`endif

//--- verification/cordic_divider_tb.sv
/*
 * testbench for the linear mode cordic divider
 * directed tests checked against an integer model of the
 * shift selection and update rule
 */

`timescale 1ns/100ps

module cordic_divider_tb;

    logic                                  clk;
    logic                                  rst_n;
    logic                                  init;
    logic [cordic_div_pkg::data_w-1:0]     dividend;
    logic [cordic_div_pkg::data_w-1:0]     divisor;
    logic [cordic_div_pkg::result_w-1:0]   quotient;
    logic                                  done;

    // result bookkeeping
    int          err_cnt   = 0;
    int          check_cnt = 0;
    int          test_cnt  = 0;
    int          cycle_cnt = 0;
    // random operand source
    logic [31:0] lcg_state = 32'h6be3_aa86;

    // reset, 4 quadrants, 2 limit cases, 20 random, restart counted twice
    localparam int n_runs      = 1 + 4 + 2 + 20 + 2;
    localparam int cycle_limit = 40 * n_runs + 3;

    cordic_divider dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .init     (init),
        .dividend (dividend),
        .divisor  (divisor),
        .quotient (quotient),
        .done     (done)
    );

    `include "cordic_div_tb_tasks.svh"

    //////////////////////////////////////////////////////////////////////
    // clock and run limit
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout, the run is still going after %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst_n    = 1'b0;
        init     = 1'b0;
        dividend = '0;
        divisor  = '0;
        // reset held for three edges
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        reset_state_check();
        sign_quadrants();
        zero_and_limit_cases();
        random_operands();
        restart_during_run();
        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- verilog/cordic_div_control.sv
/*
 * cordic divider control
 * run enable, stop decision, step counter and done pulse
 */

`timescale 1ns/100ps

module cordic_div_control (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 init,
    input  logic [cordic_div_pkg::data_w-1:0]    y,
    input  logic [cordic_div_pkg::shift_w-1:0]   shift,
    output logic                                 step,
    output logic                                 finish,
    output logic                                 done
);

    // run in progress
    logic                                en;
    // updates taken in this run
    logic [cordic_div_pkg::step_w-1:0]   step_cnt;
    // any of the three stop causes
    logic                                stop;

    //////////////////////////////////////////////////////////////////////
    // stop decision
    //////////////////////////////////////////////////////////////////////

    // shift too fine, residual used up, or step budget spent
    assign stop = (shift >= cordic_div_pkg::shift_w'(cordic_div_pkg::stop_shift))
               || ($signed(y) <= 1)
               || (step_cnt >= cordic_div_pkg::step_w'(cordic_div_pkg::max_steps));

    // init wins over an abandoned run, so no finish or step with it
    assign finish = en && !init && stop;
    assign step   = en && !init && !stop;

    //////////////////////////////////////////////////////////////////////
    // run state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en <= 1'b0;
        end else if (init) begin
            en <= 1'b1;
        end else if (finish) begin
            en <= 1'b0;
        end
    end

    // counts applied updates, restarts with every init
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_cnt <= '0;
        end else if (init) begin
            step_cnt <= '0;
        end else if (step) begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // one cycle pulse, lines up with the quotient capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // datapath must see either an update or a capture, never both
    a_step_xor_finish: assert property (@(posedge clk) disable iff (!rst_n)
        !(step && finish));

    // the limit check has to catch the counter before it runs past
    a_step_limit: assert property (@(posedge clk) disable iff (!rst_n)
        step_cnt <= cordic_div_pkg::step_w'(cordic_div_pkg::max_steps));

    // back to back done only after a fresh operation
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> (!done || $past(init)));

endmodule

//--- verilog/cordic_div_datapath.sv
/*
 * cordic divider datapath
 * x/y/z registers, linear mode add/subtract step, angle weight
 * and the signed quotient register
 */

`timescale 1ns/100ps

module cordic_div_datapath (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 init,
    input  logic [cordic_div_pkg::data_w-1:0]    dividend,
    input  logic [cordic_div_pkg::data_w-1:0]    divisor,
    input  logic                                 step,
    input  logic                                 finish,
    input  logic [cordic_div_pkg::shift_w-1:0]   shift,
    output logic [cordic_div_pkg::data_w-1:0]    x,
    output logic [cordic_div_pkg::data_w-1:0]    y,
    output logic [cordic_div_pkg::result_w-1:0]  quotient
);

    // accumulated quotient, Q4.16
    logic [cordic_div_pkg::data_w-1:0]          z;
    // result sign, dividend sign xor divisor sign
    logic                                       q_sign;
    // divisor scaled for this step
    logic signed [cordic_div_pkg::data_w-1:0]   x_shr;
    // 2^(frac_w - shift) in Q4.16
    logic [cordic_div_pkg::data_w-1:0]          weight;
    // z sign extended to the output width
    logic [cordic_div_pkg::result_w-1:0]        z_ext;

    assign x_shr = $signed(x) >>> shift;

    //////////////////////////////////////////////////////////////////////
    // angle weight
    //////////////////////////////////////////////////////////////////////

    // linear mode angle is a plain power of two
    // shift 17 never updates, weight left at zero there
    always_comb begin
        weight = '0;
        if (shift >= 1 && shift <= cordic_div_pkg::shift_w'(cordic_div_pkg::frac_w)) begin
            weight = cordic_div_pkg::data_w'(1) << (cordic_div_pkg::frac_w - shift);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // iteration registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x      <= '0;
            y      <= '0;
            z      <= '0;
            q_sign <= 1'b0;
        end else if (init) begin
            // work on magnitudes, sign is reapplied at the end
            x      <= divisor[cordic_div_pkg::data_w-1] ? -divisor : divisor;
            y      <= dividend[cordic_div_pkg::data_w-1] ? -dividend : dividend;
            z      <= '0;
            q_sign <= dividend[cordic_div_pkg::data_w-1] ^ divisor[cordic_div_pkg::data_w-1];
        end else if (step) begin
            // drive the residual toward zero from either side
            if (!y[cordic_div_pkg::data_w-1]) begin
                y <= y - x_shr;
                z <= z + weight;
            end else begin
                y <= y + x_shr;
                z <= z - weight;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // result
    //////////////////////////////////////////////////////////////////////

    assign z_ext = {{(cordic_div_pkg::result_w - cordic_div_pkg::data_w)
                     {z[cordic_div_pkg::data_w-1]}}, z};

    // held until the next run finishes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            quotient <= '0;
        end else if (finish) begin
            quotient <= q_sign ? -z_ext : z_ext;
        end
    end

    // divisor magnitude only moves when a new operation is loaded
    a_x_stable: assert property (@(posedge clk) disable iff (!rst_n)
        !$past(init) |-> $stable(x));

endmodule

//--- verilog/cordic_div_pkg.sv
/*
 * cordic divider constants
 * word widths, fraction position and the shift and step limits
 * shared by the control, shift selection and datapath blocks
 */

package cordic_div_pkg;

    //////////////////////////////////////////////////////////////////////
    // word formats
    //////////////////////////////////////////////////////////////////////

    // dividend, divisor and internal x/y/z, Q4.16 plus sign
    localparam int data_w = 21;

    // fraction bits of every fixed point word
    localparam int frac_w = 16;

    // quotient, Q6.16 plus sign
    localparam int result_w = 23;

    //////////////////////////////////////////////////////////////////////
    // iteration limits
    //////////////////////////////////////////////////////////////////////

    // shift amount, holds 1 .. max_shift
    localparam int shift_w = 5;

    // residual below every threshold
    localparam int max_shift = 17;

    // a chosen shift at or above this ends the run
    localparam int stop_shift = 16;

    // update steps allowed per run, bounds a zero divisor
    localparam int max_steps = 16;

    // step counter width, must hold max_steps
    localparam int step_w = 5;

    // threshold base width so that no threshold loses bits
    localparam int thresh_w = 38;

endpackage

//--- verilog/cordic_divider.sv
/*
 * linear mode cordic divider
 * samples dividend and divisor on init, runs an adaptive shift
 * loop and pulses done with the Q6.16 quotient
 */

`timescale 1ns/100ps

module cordic_divider (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 init,
    input  logic [cordic_div_pkg::data_w-1:0]    dividend,
    input  logic [cordic_div_pkg::data_w-1:0]    divisor,
    output logic [cordic_div_pkg::result_w-1:0]  quotient,
    output logic                                 done
);

    // divisor magnitude and residual from the datapath
    logic [cordic_div_pkg::data_w-1:0]   x;
    logic [cordic_div_pkg::data_w-1:0]   y;
    // shift picked for the current cycle
    logic [cordic_div_pkg::shift_w-1:0]  shift;
    // control strobes into the datapath
    logic                                step;
    logic                                finish;

    //////////////////////////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////////////////////////

    // decides when to stop, the datapath just follows
    cordic_div_control u_control (
        .clk    (clk),
        .rst_n  (rst_n),
        .init   (init),
        .y      (y),
        .shift  (shift),
        .step   (step),
        .finish (finish),
        .done   (done)
    );

    cordic_shift_select u_shift_select (
        .x      (x),
        .y      (y),
        .shift  (shift)
    );

    cordic_div_datapath u_datapath (
        .clk      (clk),
        .rst_n    (rst_n),
        .init     (init),
        .dividend (dividend),
        .divisor  (divisor),
        .step     (step),
        .finish   (finish),
        .shift    (shift),
        .x        (x),
        .y        (y),
        .quotient (quotient)
    );

endmodule

//--- verilog/cordic_shift_select.sv
/*
 * adaptive shift selection
 * compares |y| with the scaled divisor thresholds and picks
 * the smallest passing shift, combinational
 */

`timescale 1ns/100ps

module cordic_shift_select (
    input  logic [cordic_div_pkg::data_w-1:0]    x,
    input  logic [cordic_div_pkg::data_w-1:0]    y,
    output logic [cordic_div_pkg::shift_w-1:0]   shift
);

    // magnitude of the residual
    logic [cordic_div_pkg::data_w-1:0]                  y_abs;
    // x and |y| widened so the deepest threshold keeps its bits
    logic signed [cordic_div_pkg::thresh_w-1:0]         x_ext;
    logic signed [cordic_div_pkg::thresh_w-1:0]         y_ext;
    // threshold base, 1.5 * x
    logic signed [cordic_div_pkg::thresh_w-1:0]         t_base;
    // pass[i-1] set when |y| >= t >> (i+1)
    logic [cordic_div_pkg::max_shift-2:0]               pass;

    assign y_abs = y[cordic_div_pkg::data_w-1] ? -y : y;

    assign x_ext = {{(cordic_div_pkg::thresh_w - cordic_div_pkg::data_w)
                     {x[cordic_div_pkg::data_w-1]}}, x};
    // |y| is a magnitude, zero extend even for the most negative word
    assign y_ext = {{(cordic_div_pkg::thresh_w - cordic_div_pkg::data_w){1'b0}}, y_abs};

    // x is constant over a run so t follows it without a register
    assign t_base = x_ext + (x_ext >>> 1);

    //////////////////////////////////////////////////////////////////////
    // threshold compares
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 1; i < cordic_div_pkg::max_shift; i++) begin : g_thresh
        assign pass[i-1] = (y_ext >= (t_base >>> (i + 1)));
    end

    // priority encoder, lowest passing shift wins
    // nothing passing means the residual is below the finest step
    always_comb begin
        shift = cordic_div_pkg::shift_w'(cordic_div_pkg::max_shift);
        for (int i = cordic_div_pkg::max_shift - 1; i >= 1; i--) begin
            if (pass[i-1]) begin
                shift = cordic_div_pkg::shift_w'(i);
            end
        end
    end

    // shift 0 would double the divisor step, above max_shift has no weight
    always_comb begin
        a_shift_range: assert final (shift >= 1
            && shift <= cordic_div_pkg::shift_w'(cordic_div_pkg::max_shift))
            else $error("shift out of range: %0d", shift);
    end

endmodule
